// ==== compile.f ====
+incdir+verification
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/alu.sv
design/reg_file.sv
design/execute.sv
design/data_mem.sv
design/exec_pipe_top.sv
verification/tb_exec_pipe.sv

// ==== design/alu.sv ====
// Integer ALU with equality and signed/unsigned less-than flags
`default_nettype none

module alu
    import rv_isa_pkg::*;
(
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            zero,      // a == b
    output logic            lt,        // Signed a < b
    output logic            ltu        // Unsigned a < b
);

    logic [4:0] shamt;

    assign shamt = b[4:0];             // RV32 shifts use only the low five bits

    // Flags come straight from the operands, so branches see them regardless of op
    assign zero = (a == b);
    assign lt   = ($signed(a) < $signed(b));
    assign ltu  = (a < b);

    always_comb
    begin
        case (op)
            ADD:
                result = a + b;
            SUB:
                result = a - b;
            SLL:
                result = a << shamt;
            SLT:
                result = {{(XLEN-1){1'b0}}, lt};
            SLTU:
                result = {{(XLEN-1){1'b0}}, ltu};
            XOR:
                result = a ^ b;
            SRL:
                result = a >> shamt;
            SRA:
                result = $unsigned($signed(a) >>> shamt);
            OR:
                result = a | b;
            AND:
                result = a & b;
            PASS_B:
                result = b;            // LUI
            default:
                result = '0;           // Unused encodings
        endcase
    end

endmodule

`default_nettype wire

// ==== design/data_mem.sv ====
// Word data memory for LW/SW and the MEM/WB retire register
`default_nettype none

module data_mem
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    em_valid,
    output logic    em_ready,
    input  ex_mem_t em,
    output logic    retire_valid,
    input  logic    retire_ready,
    output retire_t retire
);

    logic [XLEN-1:0]        ram [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] addr;
    logic                   em_fire;

    assign addr     = em.alu_result[DMEM_ADDR_W+1:2];   // Word index, byte offset dropped
    assign em_ready = !retire_valid || retire_ready;     // Retire register free or draining
    assign em_fire  = em_valid && em_ready;

    // Store lands on the same edge the op moves into the retire register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
                ram[i] <= '0;
        end
        else if (em_fire && em.mem_write)
            ram[addr] <= em.store_data;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            retire_valid <= 1'b0;
            retire       <= '0;
        end
        else if (em_ready)
        begin
            retire_valid <= em_valid;
            if (em_valid)
            begin
                retire.pc        <= em.pc;
                retire.rd        <= em.rd;
                retire.reg_write <= em.reg_write;
                // Synchronous read, a load never shares the edge with a store
                retire.wb_data   <= em.mem_read ? ram[addr] : em.alu_result;
                retire.br_taken  <= em.br_taken;
                retire.br_target <= em.br_target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/exec_pipe_top.sv ====
// Back-end top: register file, execute stage and memory stage
`default_nettype none

module exec_pipe_top
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    issue_valid,
    output logic    issue_ready,
    input  dec_op_t issue_op,
    output logic    retire_valid,
    input  logic    retire_ready,
    output retire_t retire
);

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            rf_we;
    logic            em_valid;
    logic            em_ready;
    ex_mem_t         em;

    // Architectural write happens as the record leaves
    assign rf_we = retire_valid && retire_ready && retire.reg_write && (retire.rd != '0);

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (issue_op.rs1),          // Read at issue
        .rs2      (issue_op.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd       (retire.rd),
        .wd       (retire.wb_data)
    );

    execute i_execute (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_valid    (retire_valid),
        .wb          (retire),
        .em_valid    (em_valid),
        .em_ready    (em_ready),
        .em          (em)
    );

    data_mem i_data_mem (
        .clk          (clk),
        .rst          (rst),
        .em_valid     (em_valid),
        .em_ready     (em_ready),
        .em           (em),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== design/execute.sv ====
// Execute stage: ID/EX capture with forwarding and load-use stall, ALU, branch resolve, EX/MEM
`default_nettype none

module execute
    import rv_isa_pkg::*, pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    output logic            issue_ready,
    input  dec_op_t         issue_op,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic            wb_valid,      // Retire register, oldest forwarding source
    input  retire_t         wb,
    output logic            em_valid,
    input  logic            em_ready,
    output ex_mem_t         em
);

    // ID/EX register
    logic            ex_valid;
    dec_op_t         ex_op;
    logic [XLEN-1:0] ex_rs1;
    logic [XLEN-1:0] ex_rs2;

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic            alu_zero;
    logic            alu_lt;
    logic            alu_ltu;
    logic            is_jump;
    logic [XLEN-1:0] ex_result;            // Value rd will receive, unless a load
    ex_mem_t         em_next;

    logic ex_hit1, ex_hit2;                // Source matches per older op
    logic em_hit1, em_hit2;
    logic wb_hit1, wb_hit2;
    logic load_hazard;
    logic em_accept;
    logic ex_accept;
    logic issue_fire;
    logic [XLEN-1:0] fwd_rs1;
    logic [XLEN-1:0] fwd_rs2;

    // Older op writes the register this source reads
    function automatic logic hit(input logic v, input logic rw,
                                 input logic [REG_ADDR_W-1:0] rd,
                                 input logic [REG_ADDR_W-1:0] src);
        return v && rw && (rd != '0) && (rd == src);
    endfunction

    // Youngest producer wins
    function automatic logic [XLEN-1:0] pick(input logic h_ex, input logic h_em,
                                             input logic h_wb,
                                             input logic [XLEN-1:0] v_ex,
                                             input logic [XLEN-1:0] v_em,
                                             input logic [XLEN-1:0] v_wb,
                                             input logic [XLEN-1:0] v_rf);
        if (h_ex)
            return v_ex;
        else if (h_em)
            return v_em;
        else if (h_wb)
            return v_wb;
        return v_rf;                        // Covers same-cycle writeback via write-through
    endfunction

    always_comb
    begin
        ex_hit1 = hit(ex_valid, ex_op.reg_write, ex_op.rd, issue_op.rs1);
        ex_hit2 = hit(ex_valid, ex_op.reg_write, ex_op.rd, issue_op.rs2);
        em_hit1 = hit(em_valid, em.reg_write, em.rd, issue_op.rs1);
        em_hit2 = hit(em_valid, em.reg_write, em.rd, issue_op.rs2);
        wb_hit1 = hit(wb_valid, wb.reg_write, wb.rd, issue_op.rs1);
        wb_hit2 = hit(wb_valid, wb.reg_write, wb.rd, issue_op.rs2);
        // Load data exists only once the load reaches the retire register
        load_hazard = (ex_op.mem_read && (ex_hit1 || ex_hit2)) ||
                      (em.mem_read && (em_hit1 || em_hit2));
    end

    assign fwd_rs1 = pick(ex_hit1, em_hit1, wb_hit1, ex_result, em.alu_result,
                          wb.wb_data, rs1_data);
    assign fwd_rs2 = pick(ex_hit2, em_hit2, wb_hit2, ex_result, em.alu_result,
                          wb.wb_data, rs2_data);

    // A stage takes new contents when empty or when its contents leave this cycle
    assign em_accept   = !em_valid || em_ready;
    assign ex_accept   = !ex_valid || em_accept;
    assign issue_ready = ex_accept && !load_hazard;
    assign issue_fire  = issue_valid && issue_ready;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_valid <= 1'b0;
            ex_op    <= '0;
            ex_rs1   <= '0;
            ex_rs2   <= '0;
        end
        else if (ex_accept)
        begin
            ex_valid <= issue_fire;        // Bubble when stalled or idle
            if (issue_fire)
            begin
                ex_op  <= issue_op;
                ex_rs1 <= fwd_rs1;
                ex_rs2 <= fwd_rs2;
            end
        end
    end

    // Operand muxes
    always_comb
    begin
        case (ex_op.a_sel)
            PC:      alu_a = ex_op.pc;
            ZERO:    alu_a = '0;
            default: alu_a = ex_rs1;
        endcase
        alu_b = (ex_op.b_sel == IMM) ? ex_op.imm : ex_rs2;
    end

    alu i_alu (
        .op     (ex_op.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_y),
        .zero   (alu_zero),
        .lt     (alu_lt),
        .ltu    (alu_ltu)
    );

    assign is_jump   = (ex_op.br_type == JAL) || (ex_op.br_type == JALR);
    assign ex_result = is_jump ? (ex_op.pc + 32'd4) : alu_y;   // Link address for jumps

    always_comb
    begin
        em_next            = '0;
        em_next.pc         = ex_op.pc;
        em_next.alu_result = ex_result;
        em_next.store_data = ex_rs2;
        em_next.rd         = ex_op.rd;
        em_next.mem_read   = ex_op.mem_read;
        em_next.mem_write  = ex_op.mem_write;
        em_next.reg_write  = ex_op.reg_write;
        case (ex_op.br_type)
            BEQ:       em_next.br_taken = alu_zero;
            BNE:       em_next.br_taken = !alu_zero;
            BLT:       em_next.br_taken = alu_lt;
            BGE:       em_next.br_taken = !alu_lt;
            BLTU:      em_next.br_taken = alu_ltu;
            BGEU:      em_next.br_taken = !alu_ltu;
            JAL, JALR: em_next.br_taken = 1'b1;
            default:   em_next.br_taken = 1'b0;
        endcase
        if (ex_op.br_type == JALR)
            em_next.br_target = (ex_rs1 + ex_op.imm) & ~32'd1;   // Bit 0 cleared
        else
            em_next.br_target = ex_op.pc + ex_op.imm;
    end

    // EX/MEM register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            em_valid <= 1'b0;
            em       <= '0;
        end
        else if (em_accept)
        begin
            em_valid <= ex_valid;
            if (ex_valid)
                em <= em_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/pipe_pkg.sv ====
// Stage-to-stage records: issued micro-op, EX/MEM contents and the retire record
`default_nettype none

package pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded op as presented on the issue port
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;         // Already sign extended by decode
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        alu_op_e               alu_op;
        a_sel_e                a_sel;
        b_sel_e                b_sel;
        br_type_e              br_type;
        logic                  mem_read;    // LW
        logic                  mem_write;   // SW
        logic                  reg_write;
    } dec_op_t;

    // Outcome of execute, waiting for the memory stage
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       alu_result;  // Also the memory byte address
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic                  br_taken;
        logic [XLEN-1:0]       br_target;
    } ex_mem_t;

    // One retired op, also the register file write port source
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic [XLEN-1:0]       wb_data;     // Load data or ALU result
        logic                  br_taken;
        logic [XLEN-1:0]       br_target;
    } retire_t;

endpackage

`default_nettype wire

// ==== design/reg_file.sv ====
// Integer register file, x0 hardwired to zero, two async reads with write-through
`default_nettype none

module reg_file
    import rv_isa_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       wd
);

    logic [XLEN-1:0] regs [1:31];      // No storage behind x0

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && (rd != '0))
            regs[rd] <= wd;
    end

    // Same-cycle write shows on the read port
    assign rs1_data = (rs1 == '0)             ? '0 :
                      (we && (rd == rs1))     ? wd : regs[rs1];
    assign rs2_data = (rs2 == '0)             ? '0 :
                      (we && (rd == rs2))     ? wd : regs[rs2];

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
// RV32I widths, memory sizing and the encodings for ALU ops, branch types and operand selects
`default_nettype none

package rv_isa_pkg;

    // Datapath and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Word-addressed data memory, 1 KiB
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = 8;      // log2(DMEM_WORDS)

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,                   // Signed set-less-than
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,                   // Arithmetic, sign fills from the left
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10                   // LUI style, result is operand B
    } alu_op_e;

    // Branch condition, NONE for ops that never redirect
    typedef enum logic [3:0] {
        NONE = 4'd0,
        BEQ  = 4'd1,
        BNE  = 4'd2,
        BLT  = 4'd3,
        BGE  = 4'd4,
        BLTU = 4'd5,
        BGEU = 4'd6,
        JAL  = 4'd7,                     // Unconditional, pc relative
        JALR = 4'd8                      // Unconditional, register relative
    } br_type_e;

    typedef enum logic [1:0] {
        RS1  = 2'd0,
        PC   = 2'd1,                     // AUIPC and jumps
        ZERO = 2'd2
    } a_sel_e;

    typedef enum logic {
        RS2 = 1'b0,
        IMM = 1'b1
    } b_sel_e;

endpackage

`default_nettype wire

// ==== verification/exec_model.svh ====
// Reference model: architectural registers, data memory, ALU and retire record prediction
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

logic [XLEN-1:0] model_regs [32];              // x0 entry never written
logic [XLEN-1:0] model_mem  [DMEM_WORDS];
retire_t         exp_q [$];                    // Expected records, oldest first

// Architectural state after reset
function automatic void model_clear();
    foreach (model_regs[i])
        model_regs[i] = '0;
    foreach (model_mem[i])
        model_mem[i] = '0;
    exp_q.delete();
endfunction

// RV32I integer semantics, shift amount from the low five bits of b
function automatic logic [XLEN-1:0] ref_alu(input alu_op_e f, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f)
        ADD:     return a + b;
        SUB:     return a - b;
        SLL:     return a << sh;
        SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLTU:    return (a < b) ? 32'd1 : 32'd0;
        XOR:     return a ^ b;
        SRL:     return a >> sh;
        SRA:     return XLEN'($signed(a) >>> sh);
        OR:      return a | b;
        AND:     return a & b;
        PASS_B:  return b;
        default: return '0;
    endcase
endfunction

// Executes one op in program order and returns the record it must retire with
function automatic retire_t apply_op(input dec_op_t op);
    retire_t                r;
    logic [XLEN-1:0]        s1;
    logic [XLEN-1:0]        s2;
    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [XLEN-1:0]        y;
    logic [DMEM_ADDR_W-1:0] widx;
    logic                   taken;
    s1 = model_regs[op.rs1];
    s2 = model_regs[op.rs2];
    a  = (op.a_sel == PC) ? op.pc : ((op.a_sel == ZERO) ? '0 : s1);
    b  = (op.b_sel == IMM) ? op.imm : s2;
    y  = ref_alu(op.alu_op, a, b);
    case (op.br_type)
        BEQ:       taken = (a == b);
        BNE:       taken = (a != b);
        BLT:       taken = ($signed(a) < $signed(b));
        BGE:       taken = ($signed(a) >= $signed(b));
        BLTU:      taken = (a < b);
        BGEU:      taken = (a >= b);
        JAL, JALR: taken = 1'b1;
        default:   taken = 1'b0;
    endcase
    if ((op.br_type == JAL) || (op.br_type == JALR))
        y = op.pc + 32'd4;                     // Link address
    widx        = y[DMEM_ADDR_W+1:2];          // Word index from the byte address
    r.pc        = op.pc;
    r.rd        = op.rd;
    r.reg_write = op.reg_write;
    r.br_taken  = taken;
    r.br_target = (op.br_type == JALR) ? ((s1 + op.imm) & ~32'd1) : (op.pc + op.imm);
    r.wb_data   = op.mem_read ? model_mem[widx] : y;
    if (op.mem_write)
        model_mem[widx] = s2;
    if (op.reg_write && (op.rd != '0))
        model_regs[op.rd] = r.wb_data;
    return r;
endfunction

`endif

// ==== verification/tb_exec_pipe.sv ====
// Testbench for the execute/retire back end: clock, reset, stimulus, assertions and watchdog
`default_nettype none

module tb_exec_pipe
    import rv_isa_pkg::*, pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD      = 4;
    localparam int          RST_CYCLES      = 16;
    localparam logic [31:0] SEED            = 32'h7a0fa1d2;
    localparam int          N_LAT           = 12;      // Latency test ops
    localparam int          N_RAND          = 60;      // Random ALU ops
    localparam int          N_BP            = 80;      // Random mix under back-pressure
    localparam int          N_DIRECTED      = 140;     // Upper bound on directed ops
    localparam int          TOTAL_OPS       = N_LAT + N_RAND + N_BP + N_DIRECTED;
    localparam int          WATCHDOG_CYCLES = 200 * TOTAL_OPS + RST_CYCLES;
    localparam int          READY_LEN       = 4096;
    localparam int          BURST_CYCLES    = 20;      // Long retire stall
    localparam int          DRAIN_CYCLES    = 200;     // Longest wait for the queue to empty

    logic    clk = 1'b0;
    logic    rst;
    logic    issue_valid;
    logic    issue_ready;
    dec_op_t issue_op;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;

    logic [XLEN-1:0] pc_ctr;
    logic            bp_mode;                 // Random retire_ready
    logic            hold_low;                // Forces retire_ready low
    logic            timing_on;               // Ops accepted now must retire 3 edges later
    bit              ready_pattern [READY_LEN];
    int              ready_idx = 0;
    retire_t         exp_head;                // Queue head seen by the assertion
    int              exp_count;

    `include "exec_model.svh"

    exec_pipe_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_op     (issue_op),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Scoreboard, pop the retiring record then predict the accepted op
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (retire_valid && retire_ready && (exp_q.size() != 0))
                void'(exp_q.pop_front());
            if (issue_valid && issue_ready)
                exp_q.push_back(apply_op(issue_op));
            exp_count = exp_q.size();
            exp_head  = (exp_count != 0) ? exp_q[0] : '0;
        end
    end

    // Retire side consumer
    always @(posedge clk)
    begin
        #0.5;
        ready_idx = (ready_idx + 1) % READY_LEN;
        if (hold_low)
            retire_ready = 1'b0;
        else if (bp_mode)
            retire_ready = ready_pattern[ready_idx];  // About 30% low
        else
            retire_ready = 1'b1;
    end

    retire_matches_model: assert property (@(posedge clk) disable iff (rst)
        (retire_valid && retire_ready) |-> ((exp_count != 0) && (retire == exp_head)))
        else report_retire_mismatch($sampled(retire), $sampled(exp_head), $sampled(exp_count));

    issue_op_held: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && !issue_ready) |=> $stable(issue_op))
        else abort_run("issue_op changed while waiting for issue_ready");

    // No back-pressure, independent ops
    three_edge_latency: assert property (@(posedge clk) disable iff (rst)
        (timing_on && issue_valid && issue_ready) |-> ##3 (retire_valid && retire_ready))
        else abort_run("op did not retire at the third edge after acceptance");

    // Issue port open and retire port empty as reset lets go
    issue_open_after_reset: assert property (@(posedge clk) $fell(rst) |-> issue_ready)
        else abort_run($sformatf("[ERROR] issue_ready expected 1 actual %h",
                                 $sampled(issue_ready)));

    retire_idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !retire_valid)
        else abort_run($sformatf("[ERROR] retire_valid expected 0 actual %h",
                                 $sampled(retire_valid)));

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_retire_mismatch(input retire_t act, input retire_t want, input int count);
        if (count == 0)
            $display("retire handshake with no op outstanding");
        else
        begin
            if (act.pc != want.pc)
                $display("[ERROR] retire.pc expected %h actual %h", want.pc, act.pc);
            if (act.rd != want.rd)
                $display("[ERROR] retire.rd expected %h actual %h", want.rd, act.rd);
            if (act.reg_write != want.reg_write)
                $display("[ERROR] retire.reg_write expected %h actual %h",
                         want.reg_write, act.reg_write);
            if (act.wb_data != want.wb_data)
                $display("[ERROR] retire.wb_data expected %h actual %h", want.wb_data, act.wb_data);
            if (act.br_taken != want.br_taken)
                $display("[ERROR] retire.br_taken expected %h actual %h",
                         want.br_taken, act.br_taken);
            if (act.br_target != want.br_target)
                $display("[ERROR] retire.br_target expected %h actual %h",
                         want.br_target, act.br_target);
        end
        $display("Test failed");
        $fatal(1);
    endtask

    // Op builders
    function automatic dec_op_t rr_op(input alu_op_e f, input int rd, input int rs1, input int rs2);
        dec_op_t op;
        op           = '0;
        op.alu_op    = f;
        op.rd        = REG_ADDR_W'(rd);
        op.rs1       = REG_ADDR_W'(rs1);
        op.rs2       = REG_ADDR_W'(rs2);
        op.reg_write = 1'b1;
        return op;
    endfunction

    function automatic dec_op_t ri_op(input alu_op_e f, input int rd, input int rs1,
                                      input logic [XLEN-1:0] imm);
        dec_op_t op;
        op       = rr_op(f, rd, rs1, 0);
        op.b_sel = IMM;
        op.imm   = imm;
        return op;
    endfunction

    function automatic dec_op_t lui_op(input int rd, input logic [XLEN-1:0] imm);
        dec_op_t op;
        op       = ri_op(PASS_B, rd, 0, imm);
        op.a_sel = ZERO;
        return op;
    endfunction

    function automatic dec_op_t lw_op(input int rd, input int rs1, input logic [XLEN-1:0] imm);
        dec_op_t op;
        op          = ri_op(ADD, rd, rs1, imm);
        op.mem_read = 1'b1;
        return op;
    endfunction

    function automatic dec_op_t sw_op(input int rs2, input int rs1, input logic [XLEN-1:0] imm);
        dec_op_t op;
        op           = ri_op(ADD, 0, rs1, imm);
        op.rs2       = REG_ADDR_W'(rs2);
        op.reg_write = 1'b0;
        op.mem_write = 1'b1;
        return op;
    endfunction

    function automatic dec_op_t branch_op(input br_type_e bt, input int rs1, input int rs2,
                                          input logic [XLEN-1:0] imm);
        dec_op_t op;
        op           = rr_op(SUB, 0, rs1, rs2);
        op.reg_write = 1'b0;
        op.br_type   = bt;
        op.imm       = imm;
        return op;
    endfunction

    function automatic dec_op_t jump_op(input br_type_e bt, input int rd, input int rs1,
                                        input logic [XLEN-1:0] imm);
        dec_op_t op;
        op         = ri_op(ADD, rd, rs1, imm);
        op.br_type = bt;
        op.a_sel   = (bt == JAL) ? PC : RS1;
        return op;
    endfunction

    // Starts half a ns after an edge, returns half a ns after the accept edge
    task automatic send(input dec_op_t op);
        op.pc       = pc_ctr;
        pc_ctr      = pc_ctr + 32'd4;
        issue_op    = op;
        issue_valid = 1'b1;
        do
            @(posedge clk);
        while (!issue_ready);
        #0.5;
        issue_valid = 1'b0;
    endtask

    // Mode flags change at the falling edge, away from the ready driver
    task automatic set_ready_mode(input logic bp, input logic hold);
        @(negedge clk);
        bp_mode  = bp;
        hold_low = hold;
        @(posedge clk);
        #0.5;
    endtask

    // Waits for the retire port to empty the queue, up to DRAIN_CYCLES
    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < DRAIN_CYCLES))
        begin
            @(posedge clk);
            #0.5;
            n++;
        end
    endtask

    task automatic measure_latency();
        timing_on = 1'b1;
        for (int i = 0; i < N_LAT; i++)          // Sources x1 never written here
            send(ri_op(alu_op_e'($urandom_range(10)), 20 + (i % 8), 1, $urandom()));
        timing_on = 1'b0;
        wait_drain();
    endtask

    task automatic exercise_alu();
        for (int r = 1; r < 32; r++)
            send(lui_op(r, $urandom()));
        for (int f = ADD; f <= PASS_B; f++)      // Every op in both operand forms
        begin
            send(rr_op(alu_op_e'(f), 16 + (f % 8), f + 1, f + 12));
            send(ri_op(alu_op_e'(f), 24 + (f % 8), f + 2, $urandom()));
        end
        for (int i = 0; i < N_RAND; i++)
        begin
            if ($urandom_range(1) == 0)
                send(rr_op(alu_op_e'($urandom_range(10)), $urandom_range(31),
                           $urandom_range(31), $urandom_range(31)));
            else
                send(ri_op(alu_op_e'($urandom_range(10)), $urandom_range(31),
                           $urandom_range(31), $urandom()));
        end
        send(ri_op(ADD, 0, 5, 32'd123));         // Dropped write
        send(rr_op(OR, 6, 0, 0));                // x0 must still read zero
    endtask

    // Producer x10, consumer at distance d
    task automatic chain_dependents();
        for (int d = 1; d <= 4; d++)
        begin
            send(ri_op(ADD, 10, 0, 32'(1000 + d)));
            for (int k = 1; k < d; k++)
                send(ri_op(XOR, 11 + k, 3, 32'(k)));
            send(rr_op(ADD, 15, 10, 10));
        end
    endtask

    task automatic store_then_load();
        send(lui_op(7, 32'hA5A5_0000));
        send(ri_op(ADD, 8, 0, 32'h40));          // Base address
        send(sw_op(7, 8, 32'd0));
        send(sw_op(8, 8, 32'd4));
        send(lw_op(9, 8, 32'd0));                // Same word
        send(lw_op(10, 8, 32'd4));               // Other word
        send(lw_op(11, 8, 32'd8));               // Never written
        send(lw_op(12, 8, 32'd0));
        send(rr_op(ADD, 13, 12, 7));             // Load-use, rs1
        send(lw_op(14, 8, 32'd4));
        send(ri_op(XOR, 15, 3, 32'd1));
        send(rr_op(SUB, 16, 7, 14));             // Load at distance 2, rs2
        send(lw_op(17, 8, 32'd0));
        send(sw_op(17, 8, 32'd12));              // Store data from a load
        send(lw_op(18, 8, 32'd12));
    endtask

    task automatic resolve_branches();
        int              pair_a [5] = '{1, 1, 4, 3, 4};
        int              pair_b [5] = '{2, 4, 1, 4, 3};
        logic [XLEN-1:0] off;
        send(lui_op(1, 32'd5));
        send(lui_op(2, 32'd5));
        send(lui_op(3, 32'hFFFF_FFFD));          // -3, large unsigned
        send(lui_op(4, 32'd7));
        for (int t = BEQ; t <= BGEU; t++)
        begin
            for (int p = 0; p < 5; p++)
            begin
                off = (32'($urandom_range(255)) << 2) - 32'd512;
                send(branch_op(br_type_e'(t), pair_a[p], pair_b[p], off));
            end
        end
        send(jump_op(JAL, 20, 0, 32'h80));
        send(lui_op(21, 32'h0000_2001));         // Odd base
        send(jump_op(JALR, 22, 21, 32'h10));
        send(jump_op(JALR, 23, 21, 32'h0));
        send(rr_op(ADD, 24, 20, 0));             // Uses the link value
    endtask

    task automatic stall_retire_port();
        int              kind;
        int              rd;
        int              ra;
        int              rb;
        logic [XLEN-1:0] addr;
        set_ready_mode(1'b1, 1'b0);
        for (int i = 0; i < N_BP; i++)
        begin
            kind = $urandom_range(3);
            rd   = $urandom_range(7, 1);           // Few registers, many dependencies
            ra   = $urandom_range(7);
            rb   = $urandom_range(7);
            addr = 32'($urandom_range(63)) << 2;
            case (kind)
                0:       send(rr_op(alu_op_e'($urandom_range(10)), rd, ra, rb));
                1:       send(sw_op(rb, 0, addr));
                2:       send(lw_op(rd, 0, addr));
                default: send(branch_op(br_type_e'($urandom_range(6, 1)), ra, rb, addr));
            endcase
        end
        wait_drain();
        set_ready_mode(1'b1, 1'b1);
        send(ri_op(ADD, 1, 0, 32'd11));          // Fills retire register
        send(lw_op(2, 0, 32'h10));               // Waits in EX/MEM
        send(ri_op(XOR, 5, 1, 32'hFF));          // Fills ID/EX, pipeline full
        fork
            begin
                send(rr_op(ADD, 3, 2, 1));       // Blocked by the stall
                send(rr_op(XOR, 4, 3, 2));
            end
            begin
                repeat (BURST_CYCLES) @(negedge clk);
                hold_low = 1'b0;
            end
        join
        wait_drain();
        set_ready_mode(1'b0, 1'b0);
    endtask

    initial
    begin
        void'($urandom(SEED));
        foreach (ready_pattern[i])
            ready_pattern[i] = ($urandom_range(99) >= 30);
        model_clear();
        exp_count    = 0;
        exp_head     = '0;
        rst          = 1'b1;
        issue_valid  = 1'b0;
        issue_op     = '0;
        retire_ready = 1'b1;
        bp_mode      = 1'b0;
        hold_low     = 1'b0;
        timing_on    = 1'b0;
        pc_ctr       = 32'h100;
        repeat (RST_CYCLES) @(posedge clk);
        #0.5;
        rst = 1'b0;
        measure_latency();
        exercise_alu();
        chain_dependents();
        store_then_load();
        resolve_branches();
        stall_retire_port();
        wait_drain();
        repeat (8) @(posedge clk);               // Any extra retire trips the checker
        #0.5;
        if (exp_q.size() == 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
            abort_run("expected records remain at the end of the run");
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout, retire port stalled");
    end

endmodule

`default_nettype wire
